// File: filelist.f
verilog/tcb_pkg.sv
verilog/tcb_lib_decoder.sv
verilog/tcb_lib_demultiplexer.sv
verilog/tcb_lib_memory.sv
verilog/tcb_periph_regs.sv
verilog/tcb_subsystem_top.sv
tb/tcb_subsystem_props.sv
tb/tcb_subsystem_tb.sv

// File: run.sh
#!/bin/sh
# build and run the TCB subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tcb_subsystem_tb \
  -f filelist.f \
  -o tcb_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "build failed with status $build_status"
  exit "$build_status"
fi

./obj_dir/tcb_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "simulation ended with status $sim_status"
  exit "$sim_status"
fi

exit 0

// File: tb/tcb_subsystem_tb.sv
`timescale 1ns/1ps

module tcb_subsystem_tb;

  //////////////////////////////////////////////////
  // types, sizes, limits
  //////////////////////////////////////////////////

  typedef logic [tcb_pkg::ABW-1:0] adr_t;
  typedef logic [tcb_pkg::BEW-1:0] ben_t;
  typedef logic [tcb_pkg::DBW-1:0] data_t;

  // memory window depth in words
  localparam int MEM_WORDS = 1024;
  // first byte past the register window
  localparam adr_t REG_END = tcb_pkg::REG_BASE + adr_t'(16);

  // request counts per test section
  localparam int N_MEM = 12;
  localparam int N_ALT = 10;
  localparam int N_GPO = 6;
  localparam int N_GPI = 4;
  localparam int N_REQ = 3 + 3 * N_MEM + 2 * N_ALT + 2 * N_GPO + N_GPI + 1 + 10;
  // watchdog limit in clock cycles
  localparam int TIMEOUT = 10 * N_REQ + 100;

  // DUT ports
  logic              sub;
  logic              rst_n;
  logic              sub_vld;
  tcb_pkg::tcb_req_t sub_req;
  logic              sub_rdy;
  tcb_pkg::tcb_rsp_t sub_rsp;
  data_t             gpo;
  data_t             gpi;

  // model state
  data_t model_mem [MEM_WORDS];
  data_t model_gpo = '0;
  data_t model_scr = '0;

  // progress
  int   sent    = 0;
  int   trn_cnt = 0;
  int   checked = 0;
  // set until the first request after reset is accepted
  logic fresh   = 1'b1;

  tcb_subsystem_top #(
    .MPN (tcb_pkg::MPN)
  ) i_dut (
    .sub     (sub),
    .rst_n   (rst_n),
    .sub_vld (sub_vld),
    .sub_req (sub_req),
    .sub_rdy (sub_rdy),
    .sub_rsp (sub_rsp),
    .gpo     (gpo),
    .gpi     (gpi)
  );

  // 40 ns period
  initial begin
    sub = 1'b0;
    forever #20 sub = ~sub;
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // expand byte enables into a bit mask
  function automatic data_t merge_bytes(input data_t old, input data_t wdt, input ben_t ben);
    data_t mask;
    mask = '0;
    for (int b = 0; b < tcb_pkg::BEW; b++) begin
      mask[8*b +: 8] = {8{ben[b]}};
    end
    return (old & ~mask) | (wdt & mask);
  endfunction

  function automatic bit in_mem(input adr_t adr);
    return (adr & tcb_pkg::MEM_MASK) == tcb_pkg::MEM_BASE;
  endfunction

  // word offset in the register window or -1 when unmapped
  function automatic int reg_word(input adr_t adr);
    if (adr < tcb_pkg::REG_BASE || adr >= REG_END) begin
      return -1;
    end
    return int'((adr - tcb_pkg::REG_BASE) >> 2);
  endfunction

  // expected response given gpi at the transfer
  function automatic tcb_pkg::tcb_rsp_t ref_rsp(input tcb_pkg::tcb_req_t req, input data_t pins);
    tcb_pkg::tcb_rsp_t rsp;
    int                word;
    rsp.rdt = '0;
    rsp.sts = tcb_pkg::TCB_STS_OK;
    word = reg_word(req.adr);
    if (in_mem(req.adr)) begin
      if (!req.wen) begin
        rsp.rdt = model_mem[req.adr[11:2]];
      end
    end else if (word < 0) begin
      rsp.sts = tcb_pkg::TCB_STS_ERR;
    end else if (req.wen) begin
      // gpi and id are read-only
      if (word == 1 || word == 3) begin
        rsp.sts = tcb_pkg::TCB_STS_ERR;
      end
    end else begin
      case (word)
        0:       rsp.rdt = model_gpo;
        1:       rsp.rdt = pins;
        2:       rsp.rdt = model_scr;
        default: rsp.rdt = tcb_pkg::REG_ID_VALUE;
      endcase
    end
    return rsp;
  endfunction

  // only writes that land change the model
  function automatic void update_model(input tcb_pkg::tcb_req_t req);
    int word;
    word = reg_word(req.adr);
    if (req.wen) begin
      if (in_mem(req.adr)) begin
        model_mem[req.adr[11:2]] = merge_bytes(model_mem[req.adr[11:2]], req.wdt, req.ben);
      end else if (word == 0) begin
        model_gpo = merge_bytes(model_gpo, req.wdt, req.ben);
      end else if (word == 2) begin
        model_scr = merge_bytes(model_scr, req.wdt, req.ben);
      end
    end
  endfunction

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_rdt(input data_t exp, input data_t act);
    if (act !== exp) begin
      fail_run($sformatf("Error: sub_rsp.rdt expected 0x%08h actual 0x%08h", exp, act));
    end
  endtask

  task automatic check_sts(input tcb_pkg::tcb_sts_t exp, input tcb_pkg::tcb_sts_t act);
    if (act !== exp) begin
      fail_run($sformatf("Error: sub_rsp.sts expected 0x%0h actual 0x%0h", exp, act));
    end
  endtask

  task automatic check_gpo(input data_t exp, input data_t act);
    if (act !== exp) begin
      fail_run($sformatf("Error: gpo expected 0x%08h actual 0x%08h", exp, act));
    end
  endtask

  // catch each transfer, predict, compare one cycle later
  initial begin : compare_responses
    tcb_pkg::tcb_req_t req;
    tcb_pkg::tcb_rsp_t exp;
    forever begin
      @(posedge sub);
      if (rst_n && sub_vld && sub_rdy) begin
        req = sub_req;
        exp = ref_rsp(req, gpi);
        update_model(req);
        trn_cnt++;
        @(negedge sub);
        check_rdt(exp.rdt, sub_rsp.rdt);
        check_sts(exp.sts, sub_rsp.sts);
        check_gpo(model_gpo, gpo);
        checked++;
      end
    end
  end

  // watchdog
  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge sub);
      cycles++;
      if (cycles > TIMEOUT) begin
        fail_run($sformatf("Timeout: the run did not finish within %0d cycles", TIMEOUT));
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // distinct memory words spread over the window
  function automatic adr_t mem_adr(input int i);
    return adr_t'(((i * 67 + 5) % MEM_WORDS) * 4);
  endfunction

  function automatic adr_t reg_adr(input logic [1:0] ofs);
    return tcb_pkg::REG_BASE + adr_t'({ofs, 2'b00});
  endfunction

  // drive one request from a falling edge and wait for its transfer
  // memory accepts at once and registers after one wait state
  task automatic issue(input logic wen, input adr_t adr, input ben_t ben, input data_t wdt);
    int target;
    int waited;
    int expect_n;
    target   = sent + 1;
    expect_n = (in_mem(adr) && !fresh) ? 1 : 2;
    sub_vld     = 1'b1;
    sub_req.wen = wen;
    sub_req.adr = adr;
    sub_req.ben = ben;
    sub_req.wdt = wdt;
    gpi         = data_t'($urandom);
    waited      = 0;
    while (trn_cnt < target) begin
      @(negedge sub);
      // gpi keeps moving while the request waits
      gpi = data_t'($urandom);
      waited++;
    end
    if (waited != expect_n) begin
      fail_run($sformatf("Error: request to 0x%04h accepted after %0d cycles, expected %0d",
                         adr, waited, expect_n));
    end
    sent  = target;
    fresh = 1'b0;
  endtask

  task automatic idle(input int n);
    sub_vld = 1'b0;
    repeat (n) @(negedge sub);
  endtask

  initial begin : stimulus
    void'($urandom(99));
    rst_n   = 1'b0;
    sub_vld = 1'b0;
    sub_req = '0;
    gpi     = '0;
    repeat (3) @(posedge sub);
    @(negedge sub);
    rst_n = 1'b1;

    // write right after reset then read the reset values
    issue(1'b1, 16'h0000, '1, data_t'($urandom));
    issue(1'b0, reg_adr(tcb_pkg::REG_GPO), '1, '0);
    issue(1'b0, reg_adr(tcb_pkg::REG_SCR), '1, '0);
    idle(1);

    // memory with full words first so no byte stays unknown
    for (int i = 0; i < N_MEM; i++) begin
      issue(1'b1, mem_adr(i), '1, data_t'($urandom));
    end
    for (int i = 0; i < N_MEM; i++) begin
      issue(1'b1, mem_adr(i), ben_t'($urandom), data_t'($urandom));
    end
    for (int i = 0; i < N_MEM; i++) begin
      issue(1'b0, mem_adr(i), '1, '0);
    end
    idle(2);

    // alternating ports with vld held high
    for (int i = 0; i < N_ALT; i++) begin
      issue(i[0], mem_adr(i), ben_t'($urandom), data_t'($urandom));
      issue(i[1], reg_adr(i[2] ? tcb_pkg::REG_GPO : tcb_pkg::REG_SCR),
            ben_t'($urandom), data_t'($urandom));
    end
    idle(1);

    // gpo with partial byte enables
    for (int i = 0; i < N_GPO; i++) begin
      issue(1'b1, reg_adr(tcb_pkg::REG_GPO), ben_t'($urandom), data_t'($urandom));
      issue(1'b0, reg_adr(tcb_pkg::REG_GPO), '1, '0);
    end

    // gpi sampling and identifier
    for (int i = 0; i < N_GPI; i++) begin
      issue(1'b0, reg_adr(tcb_pkg::REG_GPI), '1, '0);
    end
    issue(1'b0, reg_adr(tcb_pkg::REG_ID), '1, '0);
    idle(1);

    // error cases then gpo and scratch read back unchanged
    issue(1'b1, reg_adr(tcb_pkg::REG_GPI), '1, data_t'($urandom));
    issue(1'b1, reg_adr(tcb_pkg::REG_ID), '1, data_t'($urandom));
    issue(1'b0, 16'h4000, '1, '0);
    issue(1'b1, 16'h4000, '1, data_t'($urandom));
    issue(1'b0, 16'h8010, '1, '0);
    issue(1'b1, 16'h8010, '1, data_t'($urandom));
    issue(1'b0, 16'hF000, '1, '0);
    issue(1'b1, 16'h8018, '1, data_t'($urandom));
    issue(1'b0, reg_adr(tcb_pkg::REG_GPO), '1, '0);
    issue(1'b0, reg_adr(tcb_pkg::REG_SCR), '1, '0);
    idle(2);

    if (checked == N_REQ && sent == N_REQ) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      fail_run($sformatf("only %0d of %0d responses were checked", checked, N_REQ));
    end
  end

endmodule

// File: tb/tcb_subsystem_props.sv
`timescale 1ns/1ps

module tcb_subsystem_props #(
  // number of manager ports, registers on the last one
  parameter int unsigned MPN = 2
)(
  input logic              sub,
  input logic              rst_n,
  input logic              sub_vld,
  input tcb_pkg::tcb_req_t sub_req,
  input logic              sub_rdy,
  input logic [MPN-1:0]    man_vld,
  input logic [MPN-1:0]    man_rdy
);

  // register block port index
  localparam int unsigned RP = MPN - 1;

  // nobody is ready in the first cycle out of reset
  assert property (@(posedge sub) $rose(rst_n) |-> !sub_rdy)
    else $error("sub_rdy high in the first cycle after reset");

  // stalled request holds still
  assert property (@(posedge sub) disable iff (!rst_n)
    sub_vld && !sub_rdy |=> sub_vld && $stable(sub_req))
    else $error("request dropped or changed while sub_rdy was low");

  // new vld toward the registers always sees one wait state
  assert property (@(posedge sub) disable iff (!rst_n)
    man_vld[RP] && !$past(man_vld[RP] && !man_rdy[RP]) |-> !man_rdy[RP])
    else $error("register port ready in the first cycle of a request");

endmodule

bind tcb_subsystem_top tcb_subsystem_props #(
  .MPN (MPN)
) i_props (
  .sub     (sub),
  .rst_n   (rst_n),
  .sub_vld (sub_vld),
  .sub_req (sub_req),
  .sub_rdy (sub_rdy),
  .man_vld (man_vld),
  .man_rdy (man_rdy)
);

// File: verilog/tcb_subsystem_top.sv
`timescale 1ns/1ps

module tcb_subsystem_top #(
  // number of manager ports on the demultiplexer
  parameter int unsigned MPN = tcb_pkg::MPN
)(
  // clock and reset
  input  logic                    sub,
  input  logic                    rst_n,
  // TCB subordinate port, the manager connects here
  input  logic                    sub_vld,
  input  tcb_pkg::tcb_req_t       sub_req,
  output logic                    sub_rdy,
  output tcb_pkg::tcb_rsp_t       sub_rsp,
  // general purpose pins
  output logic [tcb_pkg::DBW-1:0] gpo,
  input  logic [tcb_pkg::DBW-1:0] gpi
);

  //////////////////////////////////////////////////
  // configuration
  //////////////////////////////////////////////////

  // select width
  localparam int unsigned MPL = (MPN > 1) ? $clog2(MPN) : 1;
  // memory fills its 4 KiB window
  localparam int unsigned MEM_WORDS = 1024;
  // identifier seen by software
  localparam logic [tcb_pkg::DBW-1:0] ID_VALUE = tcb_pkg::REG_ID_VALUE;

  //////////////////////////////////////////////////
  // interconnect wires
  //////////////////////////////////////////////////

  logic [MPL-1:0]    sel;
  logic [MPN-1:0]    man_vld;
  tcb_pkg::tcb_req_t man_req;
  logic [MPN-1:0]    man_rdy;
  tcb_pkg::tcb_rsp_t man_rsp [MPN-1:0];

  //////////////////////////////////////////////////
  // instances
  //////////////////////////////////////////////////

  // address to port
  tcb_lib_decoder #(
    .MPN (MPN)
  ) i_decoder (
    .adr (sub_req.adr),
    .sel (sel)
  );

  // routing
  tcb_lib_demultiplexer #(
    .MPN (MPN)
  ) i_demux (
    .sub     (sub),
    .rst_n   (rst_n),
    .sel     (sel),
    .sub_vld (sub_vld),
    .sub_req (sub_req),
    .sub_rdy (sub_rdy),
    .sub_rsp (sub_rsp),
    .man_vld (man_vld),
    .man_req (man_req),
    .man_rdy (man_rdy),
    .man_rsp (man_rsp)
  );

  // port 0, memory window
  tcb_lib_memory #(
    .MEM_WORDS (MEM_WORDS)
  ) i_memory (
    .sub   (sub),
    .rst_n (rst_n),
    .vld   (man_vld[0]),
    .req   (man_req),
    .rdy   (man_rdy[0]),
    .rsp   (man_rsp[0])
  );

  // last port, catches every other address
  tcb_periph_regs #(
    .ID_VALUE (ID_VALUE)
  ) i_regs (
    .sub   (sub),
    .rst_n (rst_n),
    .vld   (man_vld[MPN-1]),
    .req   (man_req),
    .rdy   (man_rdy[MPN-1]),
    .rsp   (man_rsp[MPN-1]),
    .gpi   (gpi),
    .gpo   (gpo)
  );

  // ports in between, if any, answer with an error
  for (genvar i = 1; i < MPN - 1; i++) begin : gen_tie
    assign man_rdy[i] = 1'b1;
    assign man_rsp[i] = '{rdt: '0, sts: tcb_pkg::TCB_STS_ERR};
  end

endmodule

// File: verilog/tcb_periph_regs.sv
`timescale 1ns/1ps

module tcb_periph_regs #(
  // value read back from the identifier register
  parameter logic [tcb_pkg::DBW-1:0] ID_VALUE = tcb_pkg::REG_ID_VALUE
)(
  // clock and reset
  input  logic                    sub,
  input  logic                    rst_n,
  // TCB subordinate port
  input  logic                    vld,
  input  tcb_pkg::tcb_req_t       req,
  output logic                    rdy,
  output tcb_pkg::tcb_rsp_t       rsp,
  // pins
  input  logic [tcb_pkg::DBW-1:0] gpi,
  output logic [tcb_pkg::DBW-1:0] gpo
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // wait flag, doubles as ready
  logic                    wt;
  logic                    trn;
  // address decode
  logic                    hit;
  logic [1:0]              ofs;
  logic                    err;
  // scratch register
  logic [tcb_pkg::DBW-1:0] scr;
  // read mux and response registers
  logic [tcb_pkg::DBW-1:0] rdt_nxt;
  logic [tcb_pkg::DBW-1:0] rdt;
  tcb_pkg::tcb_sts_t       sts;

  assign rdy = wt;
  assign trn = vld & wt;

  // inside the 16 byte register window
  assign hit = req.adr[tcb_pkg::ABW-1:4] == tcb_pkg::REG_BASE[tcb_pkg::ABW-1:4];
  assign ofs = req.adr[3:2];

  // unmapped, or a write to a read-only register
  assign err = ~hit | (req.wen & ((ofs == tcb_pkg::REG_GPI) | (ofs == tcb_pkg::REG_ID)));

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // one wait state
  // set by a pending vld, cleared by the transfer
  always_ff @(posedge sub) begin
    if (!rst_n) begin
      wt <= 1'b0;
    end else if (trn) begin
      wt <= 1'b0;
    end else if (vld) begin
      wt <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  // byte-enabled writes, erroneous accesses change nothing
  always_ff @(posedge sub) begin
    if (!rst_n) begin
      gpo <= '0;
      scr <= '0;
    end else if (trn && req.wen && !err) begin
      if (ofs == tcb_pkg::REG_GPO) begin
        gpo <= tcb_pkg::byte_merge(gpo, req.wdt, req.ben);
      end
      if (ofs == tcb_pkg::REG_SCR) begin
        scr <= tcb_pkg::byte_merge(scr, req.wdt, req.ben);
      end
    end
  end

  // read mux, gpi taken straight from the pins
  always_comb begin
    case (ofs)
      tcb_pkg::REG_GPO: rdt_nxt = gpo;
      tcb_pkg::REG_GPI: rdt_nxt = gpi;
      tcb_pkg::REG_SCR: rdt_nxt = scr;
      default:          rdt_nxt = ID_VALUE;
    endcase
  end

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  // status registered at the transfer
  always_ff @(posedge sub) begin
    if (!rst_n) begin
      sts <= tcb_pkg::TCB_STS_OK;
    end else if (trn) begin
      sts <= err ? tcb_pkg::TCB_STS_ERR : tcb_pkg::TCB_STS_OK;
    end
  end

  // data, zero for writes and errors
  // gpi gets sampled here
  always_ff @(posedge sub) begin
    if (trn) begin
      rdt <= (req.wen || err) ? '0 : rdt_nxt;
    end
  end

  assign rsp = '{rdt: rdt, sts: sts};

endmodule

// File: verilog/tcb_lib_memory.sv
`timescale 1ns/1ps

module tcb_lib_memory #(
  // memory depth in words
  parameter  int unsigned MEM_WORDS = 1024,
  // word address width
  localparam int unsigned MAW = $clog2(MEM_WORDS)
)(
  // clock and reset
  input  logic               sub,
  input  logic               rst_n,
  // TCB subordinate port
  input  logic               vld,
  input  tcb_pkg::tcb_req_t  req,
  output logic               rdy,
  output tcb_pkg::tcb_rsp_t  rsp
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // word storage
  logic [tcb_pkg::DBW-1:0] mem [MEM_WORDS];

  // word index from the byte address
  logic [MAW-1:0]          idx;
  // transfer
  logic                    trn;
  // registered read data
  logic [tcb_pkg::DBW-1:0] rdt;

  // drop the byte offset bits
  assign idx = req.adr[2 +: MAW];
  assign trn = vld & rdy;

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // no wait states, ready as soon as reset is gone
  // stays low through the first cycle after reset
  always_ff @(posedge sub) begin
    if (!rst_n) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // array access
  //////////////////////////////////////////////////

  // write, only enabled bytes change
  always_ff @(posedge sub) begin
    if (trn && req.wen) begin
      mem[idx] <= tcb_pkg::byte_merge(mem[idx], req.wdt, req.ben);
    end
  end

  // read data captured at the transfer
  // writes return zero data
  always_ff @(posedge sub) begin
    if (trn) begin
      rdt <= req.wen ? '0 : mem[idx];
    end
  end

  // memory never reports an error
  assign rsp = '{rdt: rdt, sts: tcb_pkg::TCB_STS_OK};

endmodule

// File: verilog/tcb_lib_demultiplexer.sv
`timescale 1ns/1ps

module tcb_lib_demultiplexer #(
  // number of manager ports
  parameter  int unsigned MPN = 2,
  // select width
  localparam int unsigned MPL = (MPN > 1) ? $clog2(MPN) : 1
)(
  // clock and reset
  input  logic               sub,
  input  logic               rst_n,
  // port select from the decoder
  input  logic [MPL-1:0]     sel,
  // subordinate side, manager connects here
  input  logic               sub_vld,
  input  tcb_pkg::tcb_req_t  sub_req,
  output logic               sub_rdy,
  output tcb_pkg::tcb_rsp_t  sub_rsp,
  // manager side, subordinates connect here
  output logic [MPN-1:0]     man_vld,
  output tcb_pkg::tcb_req_t  man_req,
  input  logic [MPN-1:0]     man_rdy,
  input  tcb_pkg::tcb_rsp_t  man_rsp [MPN-1:0]
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // transfer on the subordinate side
  logic           sub_trn;
  // select of the last transfer, picks the response
  logic [MPL-1:0] man_sel;

  assign sub_trn = sub_vld & sub_rdy;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  // remember where the last transfer went
  // response comes back one cycle later from there
  always_ff @(posedge sub) begin
    if (!rst_n) begin
      man_sel <= '0;
    end else if (sub_trn) begin
      man_sel <= sel;
    end
  end

  //////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////

  // valid only toward the selected port
  for (genvar i = 0; i < MPN; i++) begin : gen_vld
    assign man_vld[i] = (sel == MPL'(i)) ? sub_vld : 1'b0;
  end

  // payload is shared, ports ignore it without vld
  assign man_req = sub_req;

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  // ready follows the current select
  assign sub_rdy = man_rdy[sel];

  // response follows the registered select,
  // so a new request to another port may overlap it
  assign sub_rsp = man_rsp[man_sel];

endmodule

// File: verilog/tcb_lib_decoder.sv
`timescale 1ns/1ps

module tcb_lib_decoder #(
  // number of manager ports
  parameter  int unsigned MPN = 2,
  // select width, at least one bit
  localparam int unsigned MPL = (MPN > 1) ? $clog2(MPN) : 1
)(
  input  logic [tcb_pkg::ABW-1:0] adr,
  output logic [MPL-1:0]          sel
);

  //////////////////////////////////////////////////
  // region table
  //////////////////////////////////////////////////

  // region index matches the manager port index
  // last port has no region, it catches the rest
  function automatic logic region_hit(
    input int unsigned              idx,
    input logic [tcb_pkg::ABW-1:0]  a
  );
    logic hit;
    case (idx)
      // memory window
      0: hit = (a & tcb_pkg::MEM_MASK) == (tcb_pkg::MEM_BASE & tcb_pkg::MEM_MASK);
      // no other explicit regions
      default: hit = 1'b0;
    endcase
    return hit;
  endfunction

  //////////////////////////////////////////////////
  // select
  //////////////////////////////////////////////////

  // default to the catch-all port
  // then scan regions from the highest down,
  // so the lowest matching index wins
  always_comb begin
    sel = MPL'(MPN - 1);
    for (int i = int'(MPN) - 2; i >= 0; i--) begin
      if (region_hit(i, adr)) begin
        sel = MPL'(i);
      end
    end
  end

  // note the decoder is purely combinational,
  // the demultiplexer registers the select on each transfer

endmodule

// File: verilog/tcb_pkg.sv
package tcb_pkg;

  //////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////

  // byte address bus
  localparam int unsigned ABW = 16;
  // data bus
  localparam int unsigned DBW = 32;
  // one enable per data byte
  localparam int unsigned BEW = DBW / 8;

  // request payload
  typedef struct packed {
    logic           wen;
    logic [ABW-1:0] adr;
    logic [BEW-1:0] ben;
    logic [DBW-1:0] wdt;
  } tcb_req_t;

  // response status
  typedef enum logic {
    TCB_STS_OK  = 1'b0,
    TCB_STS_ERR = 1'b1
  } tcb_sts_t;

  // response payload
  typedef struct packed {
    logic [DBW-1:0] rdt;
    tcb_sts_t       sts;
  } tcb_rsp_t;

  //////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////

  // manager ports, memory then register block
  localparam int unsigned MPN = 2;

  // 4 KiB memory window
  localparam logic [ABW-1:0] MEM_BASE = 16'h0000;
  localparam logic [ABW-1:0] MEM_MASK = 16'hF000;

  // register window and word offsets
  localparam logic [ABW-1:0] REG_BASE = 16'h8000;
  localparam logic [1:0] REG_GPO = 2'd0;
  localparam logic [1:0] REG_GPI = 2'd1;
  localparam logic [1:0] REG_SCR = 2'd2;
  localparam logic [1:0] REG_ID  = 2'd3;

  // identifier constant
  localparam logic [DBW-1:0] REG_ID_VALUE = 32'h7CB0_0001;

  // merge write data into an old word, byte by byte
  function automatic logic [DBW-1:0] byte_merge(
    input logic [DBW-1:0] old,
    input logic [DBW-1:0] wdt,
    input logic [BEW-1:0] ben
  );
    logic [DBW-1:0] tmp;
    tmp = old;
    for (int b = 0; b < BEW; b++) begin
      if (ben[b]) begin
        tmp[8*b +: 8] = wdt[8*b +: 8];
      end
    end
    return tmp;
  endfunction

endpackage
